//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_int_mem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
verilog/int_mem_pkg.sv
verilog/mem_bus_if.sv
verilog/boot_rom.sv
verilog/boot_loader.sv
verilog/ram_access_ctrl.sv
verilog/dual_port_ram.sv
verilog/int_mem.sv
tests/int_mem_assert.sv
tests/tb_int_mem.sv

//--- tests/int_mem_assert.sv
`timescale 1ns/100ps
`default_nettype none

module int_mem_sva (
   input wire logic clk,
   input wire logic rst,
   input wire logic o_loaded,
   input wire logic o_i_ready,
   input wire logic o_d_ready
);

   // no cpu response before the image is in place
   a_ready_after_load: assert property (@(posedge clk) disable iff (rst)
      (o_i_ready || o_d_ready) |-> o_loaded)
      else $error("cpu ready seen while not loaded");

   // ready pulses last one cycle
   a_i_ready_pulse: assert property (@(posedge clk) disable iff (rst)
      o_i_ready |=> !o_i_ready)
      else $error("instruction ready held longer than one cycle");

   a_d_ready_pulse: assert property (@(posedge clk) disable iff (rst)
      o_d_ready |=> !o_d_ready)
      else $error("data ready held longer than one cycle");

   // loaded stays up until the next reset
   a_loaded_sticky: assert property (@(posedge clk) disable iff (rst)
      o_loaded |=> o_loaded)
      else $error("loaded flag fell outside reset");

endmodule

bind int_mem int_mem_sva u_sva (
   .clk        (clk),
   .rst        (rst),
   .o_loaded   (o_loaded),
   .o_i_ready  (o_i_ready),
   .o_d_ready  (o_d_ready)
);

`default_nettype wire

//--- tests/tb_int_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_int_mem;

   localparam int CLK_HALF    = 4;
   localparam int MAX_ENTRIES = 64;

   // boot image layout as the cpu expects it
   localparam logic [31:0] IMAGE_TAG   = 32'hB007_0000;
   localparam int          IMAGE_BASE  = 240;
   localparam int          IMAGE_WORDS = 16;

   typedef struct {
      bit          is_data;
      bit          boot;
      bit          write;
      bit          with_next;
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } entry_t;

   logic        clk;
   logic        rst;
   logic        i_boot;
   logic        i_i_valid;
   logic [7:0]  i_i_addr;
   logic        o_i_ready;
   logic [31:0] o_i_rdata;
   logic        i_d_valid;
   logic [7:0]  i_d_addr;
   logic [31:0] i_d_wdata;
   logic [3:0]  i_d_wstrb;
   logic        o_d_ready;
   logic [31:0] o_d_rdata;
   logic        o_loaded;

   entry_t      tbl [MAX_ENTRIES];
   int          num_entries;
   logic [31:0] model [256];
   int          errors = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   int_mem u_dut (
      .clk        (clk),
      .rst        (rst),
      .i_boot     (i_boot),
      .i_i_valid  (i_i_valid),
      .i_i_addr   (i_i_addr),
      .o_i_ready  (o_i_ready),
      .o_i_rdata  (o_i_rdata),
      .i_d_valid  (i_d_valid),
      .i_d_addr   (i_d_addr),
      .i_d_wdata  (i_d_wdata),
      .i_d_wstrb  (i_d_wstrb),
      .o_d_ready  (o_d_ready),
      .o_d_rdata  (o_d_rdata),
      .o_loaded   (o_loaded)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // run limit covers loading plus a budget per entry
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: ready never came within %0d cycles", cycle_limit);
         $display("errors: %0d", errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   // boot mode points cpu address 0 at the image
   function automatic logic [7:0] map_addr(input logic [7:0] addr, input bit boot);
      return boot ? addr + 8'(IMAGE_BASE) : addr;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] word;
      word = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            word[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return word;
   endfunction

   task automatic add_entry(input bit is_data, input bit boot, input bit write,
                            input bit with_next, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb);
      tbl[num_entries].is_data   = is_data;
      tbl[num_entries].boot      = boot;
      tbl[num_entries].write     = write;
      tbl[num_entries].with_next = with_next;
      tbl[num_entries].addr      = addr;
      tbl[num_entries].wdata     = wdata;
      tbl[num_entries].wstrb     = wstrb;
      num_entries++;
   endtask

   task automatic build_table();
      num_entries = 0;
      // data read raised while the loader still runs
      add_entry(1'b1, 1'b1, 1'b0, 1'b0, 8'd2, '0, '0);
      for (int k = 0; k < IMAGE_WORDS; k++) begin
         add_entry(1'b0, 1'b1, 1'b0, 1'b0, 8'(k), '0, '0);
      end
      for (int k = 0; k < IMAGE_WORDS; k++) begin
         add_entry(1'b1, 1'b1, 1'b0, 1'b0, 8'(k), '0, '0);
      end
      // write through the boot window and read back unmapped
      add_entry(1'b1, 1'b1, 1'b1, 1'b0, 8'd3, $urandom, 4'hf);
      add_entry(1'b1, 1'b0, 1'b0, 1'b0, 8'd243, '0, '0);
      add_entry(1'b0, 1'b0, 1'b0, 1'b0, 8'd243, '0, '0);
      // partial strobes on top of a full word
      add_entry(1'b1, 1'b0, 1'b1, 1'b0, 8'd20, $urandom, 4'hf);
      add_entry(1'b1, 1'b0, 1'b1, 1'b0, 8'd20, $urandom, 4'b0101);
      add_entry(1'b1, 1'b0, 1'b0, 1'b0, 8'd20, '0, '0);
      add_entry(1'b0, 1'b0, 1'b0, 1'b0, 8'd20, '0, '0);
      // pairs raised in the same cycle
      add_entry(1'b0, 1'b0, 1'b0, 1'b1, 8'd247, '0, '0);
      add_entry(1'b1, 1'b0, 1'b0, 1'b0, 8'd20, '0, '0);
      add_entry(1'b0, 1'b0, 1'b0, 1'b1, 8'd20, '0, '0);
      add_entry(1'b1, 1'b0, 1'b1, 1'b0, 8'd30, $urandom, 4'b1100);
      add_entry(1'b1, 1'b0, 1'b0, 1'b0, 8'd30, '0, '0);
      add_entry(1'b0, 1'b1, 1'b0, 1'b1, 8'd3, '0, '0);
      add_entry(1'b1, 1'b1, 1'b0, 1'b0, 8'd0, '0, '0);
   endtask

   task automatic run_entry(input int idx);
      entry_t      e;
      logic [7:0]  ram_addr;
      logic [31:0] expected;
      logic [31:0] got;
      bit          done;
      bit          loaded_at_drive;
      int          waited;
      e        = tbl[idx];
      ram_addr = map_addr(e.addr, e.boot);
      expected = model[ram_addr];
      if (e.write) begin
         model[ram_addr] = merge_bytes(model[ram_addr], e.wdata, e.wstrb);
      end
      @(posedge clk);
      #1;
      i_boot = e.boot;
      if (e.is_data) begin
         i_d_valid = 1'b1;
         i_d_addr  = e.addr;
         i_d_wdata = e.wdata;
         i_d_wstrb = e.write ? e.wstrb : 4'h0;
      end else begin
         i_i_valid = 1'b1;
         i_i_addr  = e.addr;
      end
      loaded_at_drive = o_loaded;
      waited          = 0;
      done            = 1'b0;
      got             = '0;
      // ready and rdata are settled by the falling edge
      while (!done) begin
         @(negedge clk);
         waited++;
         if (e.is_data ? o_d_ready : o_i_ready) begin
            done = 1'b1;
            got  = e.is_data ? o_d_rdata : o_i_rdata;
            if (!o_loaded) begin
               errors++;
               $display("** Error at %0t: entry %0d ready before loading ended", $time, idx);
            end
         end
      end
      // one cycle in the controller and one in the ram once loaded
      if (loaded_at_drive && waited != 3) begin
         errors++;
         $display("** Error at %0t: entry %0d ready %0d cycles after valid, expected 2",
                  $time, idx, waited - 1);
      end
      if (!e.write && got !== expected) begin
         errors++;
         $display("** Error at %0t: entry %0d %s read at %0d gave %h, expected %h",
                  $time, idx, e.is_data ? "data" : "instr", e.addr, got, expected);
      end
      @(posedge clk);
      #1;
      if (e.is_data) begin
         i_d_valid = 1'b0;
         i_d_wstrb = 4'h0;
      end else begin
         i_i_valid = 1'b0;
      end
   endtask

   initial begin
      int idx;
      void'($urandom(78));
      rst       = 1'b1;
      i_boot    = 1'b0;
      i_i_valid = 1'b0;
      i_i_addr  = '0;
      i_d_valid = 1'b0;
      i_d_addr  = '0;
      i_d_wdata = '0;
      i_d_wstrb = '0;
      build_table();
      for (int w = 0; w < 256; w++) begin
         model[w] = '0;
      end
      for (int k = 0; k < IMAGE_WORDS; k++) begin
         model[IMAGE_BASE + k] = IMAGE_TAG + 32'(k);
      end
      cycle_limit = 64 + 8 * num_entries + 32;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      if (o_loaded) begin
         errors++;
         $display("** Error at %0t: loaded flag set right after reset", $time);
      end
      idx = 0;
      while (idx < num_entries) begin
         if (tbl[idx].with_next) begin
            fork
               run_entry(idx);
               run_entry(idx + 1);
            join
            idx += 2;
         end else begin
            run_entry(idx);
            idx++;
         end
      end
      repeat (2) @(posedge clk);
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/boot_loader.sv
`timescale 1ns/100ps
`default_nettype none

module boot_loader (
   input  wire logic                                clk,
   input  wire logic                                rst,

   // rom side
   output logic      [int_mem_pkg::ROM_ADDR_W-1:0]  o_rom_addr,
   input  wire logic [int_mem_pkg::DATA_W-1:0]      i_rom_rdata,

   // write bus toward the ram data port
   mem_bus_if.master                                ld,

   output logic                                     o_loaded
);

   int_mem_pkg::loader_state_e        state;
   logic [int_mem_pkg::ROM_ADDR_W-1:0] word_cnt;

   // copy sequence, one word per pass
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= int_mem_pkg::LD_READ;
         word_cnt <= '0;
      end else begin
         case (state)
            // rom address out, data back next cycle
            int_mem_pkg::LD_READ: begin
               state <= int_mem_pkg::LD_WRITE;
            end
            // ram takes the request on this edge
            int_mem_pkg::LD_WRITE: begin
               state <= int_mem_pkg::LD_WAIT;
            end
            int_mem_pkg::LD_WAIT: begin
               if (ld.ready) begin
                  if (word_cnt == int_mem_pkg::ROM_LAST) begin
                     state <= int_mem_pkg::LD_DONE;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                     state    <= int_mem_pkg::LD_READ;
                  end
               end
            end
            // parked until the next reset
            default: begin
               state <= int_mem_pkg::LD_DONE;
            end
         endcase
      end
   end

   assign o_rom_addr = word_cnt;

   // rom output is stable while the counter holds
   assign ld.valid = (state == int_mem_pkg::LD_WRITE) || (state == int_mem_pkg::LD_WAIT);
   assign ld.addr  = int_mem_pkg::rom_to_ram(word_cnt);
   assign ld.wdata = i_rom_rdata;
   assign ld.wstrb = '1;

   assign o_loaded = (state == int_mem_pkg::LD_DONE);

endmodule

`default_nettype wire

//--- verilog/boot_rom.sv
`timescale 1ns/100ps
`default_nettype none

module boot_rom (
   input  wire logic                                clk,
   input  wire logic [int_mem_pkg::ROM_ADDR_W-1:0]  i_addr,
   output logic      [int_mem_pkg::DATA_W-1:0]      o_rdata
);

   logic [int_mem_pkg::DATA_W-1:0] rom [int_mem_pkg::ROM_WORDS];

   // contents follow the package fill rule
   initial begin
      for (int k = 0; k < int_mem_pkg::ROM_WORDS; k++) begin
         rom[k] = int_mem_pkg::rom_word(k);
      end
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk) begin
      o_rdata <= rom[i_addr];
   end

endmodule

`default_nettype wire

//--- verilog/dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram (
   input  wire logic  clk,
   input  wire logic  rst,

   // read only instruction port
   mem_bus_if.slave   ram_i,

   // read and byte write data port
   mem_bus_if.slave   ram_d
);

   logic [int_mem_pkg::DATA_W-1:0] mem [int_mem_pkg::RAM_WORDS];

   logic i_accept;
   logic d_accept;

   initial begin
      for (int w = 0; w < int_mem_pkg::RAM_WORDS; w++) begin
         mem[w] = '0;
      end
   end

   // first cycle of valid with no ready yet
   assign i_accept = ram_i.valid && !ram_i.ready;
   assign d_accept = ram_d.valid && !ram_d.ready;

   // one cycle ready pulse per request
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ram_i.ready <= 1'b0;
         ram_d.ready <= 1'b0;
      end else begin
         ram_i.ready <= i_accept;
         ram_d.ready <= d_accept;
      end
   end

   // instruction read sees the word from before any same edge write
   always_ff @(posedge clk) begin
      if (i_accept) begin
         ram_i.rdata <= mem[ram_i.addr];
      end
   end

   always_ff @(posedge clk) begin
      if (d_accept) begin
         ram_d.rdata <= mem[ram_d.addr];
         for (int b = 0; b < int_mem_pkg::STRB_W; b++) begin
            if (ram_d.wstrb[b]) begin
               mem[ram_d.addr][8*b +: 8] <= ram_d.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/int_mem.sv
`timescale 1ns/100ps
`default_nettype none

module int_mem (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                i_boot,

   // instruction bus
   input  wire logic                                i_i_valid,
   input  wire logic [int_mem_pkg::RAM_ADDR_W-1:0]  i_i_addr,
   output logic                                     o_i_ready,
   output logic      [int_mem_pkg::DATA_W-1:0]      o_i_rdata,

   // data bus
   input  wire logic                                i_d_valid,
   input  wire logic [int_mem_pkg::RAM_ADDR_W-1:0]  i_d_addr,
   input  wire logic [int_mem_pkg::DATA_W-1:0]      i_d_wdata,
   input  wire logic [int_mem_pkg::STRB_W-1:0]      i_d_wstrb,
   output logic                                     o_d_ready,
   output logic      [int_mem_pkg::DATA_W-1:0]      o_d_rdata,

   // high once the boot image is in ram
   output logic                                     o_loaded
);

   logic [int_mem_pkg::ROM_ADDR_W-1:0] rom_addr;
   logic [int_mem_pkg::DATA_W-1:0]     rom_rdata;

   mem_bus_if ram_i_bus ();
   mem_bus_if ram_d_bus ();
   mem_bus_if ld_bus ();

   boot_rom u_rom (
      .clk      (clk),
      .i_addr   (rom_addr),
      .o_rdata  (rom_rdata)
   );

   // copies the rom to the top of ram after reset
   boot_loader u_loader (
      .clk          (clk),
      .rst          (rst),
      .o_rom_addr   (rom_addr),
      .i_rom_rdata  (rom_rdata),
      .ld           (ld_bus.master),
      .o_loaded     (o_loaded)
   );

   ram_access_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .i_boot     (i_boot),
      .i_loaded   (o_loaded),
      .ld         (ld_bus.slave),
      .i_i_valid  (i_i_valid),
      .i_i_addr   (i_i_addr),
      .o_i_ready  (o_i_ready),
      .o_i_rdata  (o_i_rdata),
      .i_d_valid  (i_d_valid),
      .i_d_addr   (i_d_addr),
      .i_d_wdata  (i_d_wdata),
      .i_d_wstrb  (i_d_wstrb),
      .o_d_ready  (o_d_ready),
      .o_d_rdata  (o_d_rdata),
      .ram_i      (ram_i_bus.master),
      .ram_d      (ram_d_bus.master)
   );

   dual_port_ram u_ram (
      .clk    (clk),
      .rst    (rst),
      .ram_i  (ram_i_bus.slave),
      .ram_d  (ram_d_bus.slave)
   );

endmodule

`default_nettype wire

//--- verilog/int_mem_pkg.sv
`default_nettype none

package int_mem_pkg;

   // bus word geometry
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // main ram, word addressed
   localparam int RAM_ADDR_W = 8;
   localparam int RAM_WORDS  = 2 ** RAM_ADDR_W;

   // boot rom, word addressed
   localparam int ROM_ADDR_W = 4;
   localparam int ROM_WORDS  = 2 ** ROM_ADDR_W;

   // index of the final rom word
   localparam logic [ROM_ADDR_W-1:0] ROM_LAST = ROM_ADDR_W'(ROM_WORDS - 1);

   // boot image sits at the very top of the ram
   localparam logic [RAM_ADDR_W-1:0] BOOT_BASE = RAM_ADDR_W'(RAM_WORDS - ROM_WORDS);

   // rom contents: tag in the upper half, word index added on
   localparam logic [DATA_W-1:0] ROM_TAG = 32'hB007_0000;

   // fill rule for rom word k
   function automatic logic [DATA_W-1:0] rom_word(input int k);
      logic [DATA_W-1:0] word;
      word = ROM_TAG + DATA_W'(k);
      return word;
   endfunction

   // ram word that receives rom word k
   function automatic logic [RAM_ADDR_W-1:0] rom_to_ram(input logic [ROM_ADDR_W-1:0] k);
      logic [RAM_ADDR_W-1:0] addr;
      addr = BOOT_BASE + RAM_ADDR_W'(k);
      return addr;
   endfunction

   // boot loader sequence
   typedef enum logic [1:0] {
      LD_READ,
      LD_WRITE,
      LD_WAIT,
      LD_DONE
   } loader_state_e;

   // owner of the ram data port
   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_LOADER,
      GNT_CPU
   } grant_e;

endpackage

`default_nettype wire

//--- verilog/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;

   // request, held by the master until ready
   logic                                valid;
   logic [int_mem_pkg::RAM_ADDR_W-1:0]  addr;
   logic [int_mem_pkg::DATA_W-1:0]      wdata;
   // all zero means read
   logic [int_mem_pkg::STRB_W-1:0]      wstrb;

   // response, ready is a single cycle pulse
   logic                                ready;
   logic [int_mem_pkg::DATA_W-1:0]      rdata;

   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rdata
   );

endinterface

`default_nettype wire

//--- verilog/ram_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ram_access_ctrl (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                i_boot,
   input  wire logic                                i_loaded,

   // loader writes
   mem_bus_if.slave                                 ld,

   // cpu instruction port
   input  wire logic                                i_i_valid,
   input  wire logic [int_mem_pkg::RAM_ADDR_W-1:0]  i_i_addr,
   output logic                                     o_i_ready,
   output logic      [int_mem_pkg::DATA_W-1:0]      o_i_rdata,

   // cpu data port
   input  wire logic                                i_d_valid,
   input  wire logic [int_mem_pkg::RAM_ADDR_W-1:0]  i_d_addr,
   input  wire logic [int_mem_pkg::DATA_W-1:0]      i_d_wdata,
   input  wire logic [int_mem_pkg::STRB_W-1:0]      i_d_wstrb,
   output logic                                     o_d_ready,
   output logic      [int_mem_pkg::DATA_W-1:0]      o_d_rdata,

   // ram side
   mem_bus_if.master                                ram_i,
   mem_bus_if.master                                ram_d
);

   int_mem_pkg::grant_e                 grant;

   logic                                i_req_valid;
   logic [int_mem_pkg::RAM_ADDR_W-1:0]  i_req_addr;
   logic                                d_req_valid;
   logic [int_mem_pkg::RAM_ADDR_W-1:0]  d_req_addr;
   logic [int_mem_pkg::DATA_W-1:0]      d_req_wdata;
   logic [int_mem_pkg::STRB_W-1:0]      d_req_wstrb;

   // boot mode points cpu address 0 at the copied image
   function automatic logic [int_mem_pkg::RAM_ADDR_W-1:0] remap(
      input logic [int_mem_pkg::RAM_ADDR_W-1:0] addr,
      input logic                               boot
   );
      logic [int_mem_pkg::RAM_ADDR_W-1:0] ram_addr;
      ram_addr = boot ? addr + int_mem_pkg::BOOT_BASE : addr;
      return ram_addr;
   endfunction

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         grant <= int_mem_pkg::GNT_NONE;
      end else if (i_loaded) begin
         grant <= int_mem_pkg::GNT_CPU;
      end else begin
         grant <= int_mem_pkg::GNT_LOADER;
      end
   end

   // cpu requests wait here until the image is loaded
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         i_req_valid <= 1'b0;
         d_req_valid <= 1'b0;
      end else begin
         if (i_req_valid) begin
            i_req_valid <= !ram_i.ready;
         end else begin
            i_req_valid <= i_i_valid && i_loaded;
         end
         if (d_req_valid) begin
            d_req_valid <= !ram_d.ready;
         end else begin
            d_req_valid <= i_d_valid && i_loaded;
         end
      end
   end

   // payload follows the cpu while no request is pending
   always_ff @(posedge clk) begin
      if (!i_req_valid) begin
         i_req_addr <= remap(i_i_addr, i_boot);
      end
      if (!d_req_valid) begin
         d_req_addr  <= remap(i_d_addr, i_boot);
         d_req_wdata <= i_d_wdata;
         d_req_wstrb <= i_d_wstrb;
      end
   end

   // instruction port has no other master
   assign ram_i.valid = i_req_valid;
   assign ram_i.addr  = i_req_addr;
   assign ram_i.wdata = '0;
   assign ram_i.wstrb = '0;
   assign o_i_ready   = ram_i.ready;
   assign o_i_rdata   = ram_i.rdata;

   always_comb begin
      case (grant)
         int_mem_pkg::GNT_LOADER: begin
            ram_d.valid = ld.valid;
            ram_d.addr  = ld.addr;
            ram_d.wdata = ld.wdata;
            ram_d.wstrb = ld.wstrb;
         end
         int_mem_pkg::GNT_CPU: begin
            ram_d.valid = d_req_valid;
            ram_d.addr  = d_req_addr;
            ram_d.wdata = d_req_wdata;
            ram_d.wstrb = d_req_wstrb;
         end
         default: begin
            ram_d.valid = 1'b0;
            ram_d.addr  = '0;
            ram_d.wdata = '0;
            ram_d.wstrb = '0;
         end
      endcase
   end

   // response goes back to whoever holds the grant
   assign ld.ready  = (grant == int_mem_pkg::GNT_LOADER) && ram_d.ready;
   assign ld.rdata  = ram_d.rdata;
   assign o_d_ready = (grant == int_mem_pkg::GNT_CPU) && ram_d.ready;
   assign o_d_rdata = ram_d.rdata;

endmodule

`default_nettype wire
